/* db_ctrl.f */
+incdir+verilog
verilog/db_pkg.sv
verilog/db_prio_arb.sv
verilog/db_req_proxy.sv
verilog/db_key_demux.sv
verilog/db_ctrl.sv
verif/db_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the db_ctrl testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=db_ctrl_sim

verilator --binary --timing --timescale 1ns/100ps -f db_ctrl.f \
    --top-module db_ctrl_tb -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0

/* verif/db_ctrl_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "db_defs.svh"

module db_ctrl_tb;

    localparam int STALL_CYCLES = 24;
    localparam int WAIT_LIMIT   = 300;
    localparam int IDLE_LIMIT   = 5000;
    localparam int TXN_PER_CTRL = 60;

    logic             clk;
    logic             srst;
    // Index 1 is the hi controller and index 0 the lo one
    logic [1:0]       c_req;
    logic [1:0]       c_rdy;
    logic [1:0]       c_ack;
    db_pkg::db_req_t  c_cmd [2];
    db_pkg::db_resp_t c_resp [2];
    // Index is the table peripheral number
    logic [1:0]       p_req;
    logic [1:0]       p_rdy;
    logic [1:0]       p_ack;
    db_pkg::db_req_t  p_cmd [2];
    db_pkg::db_resp_t p_resp [2];

    int  seed = 71880;
    int  mismatch_cnt = 0;
    int  protocol_cnt = 0;
    int  timeout_cnt = 0;
    int  acc_cnt [2] = '{0, 0};
    int  ack_cnt [2] = '{0, 0};
    int  p_acc_cnt = 0;
    time ack_time [2] = '{0, 0};

    // Banks 0 and 1 are the tables and bank 2 is the reference model
    logic [`DB_VALUE_WID-1:0] tables [logic [`DB_KEY_WID+1:0]];
    logic [`DB_KEY_WID-1:0]   key_pool [6] = '{8'h03, 8'h1a, 8'h41, 8'h83, 8'h9a, 8'hc1};

    // Transaction in flight as the monitor sees it
    logic             busy;
    logic             reached;
    int               owner;
    db_pkg::db_req_t  exp_cmd;
    db_pkg::db_resp_t exp_resp;

    db_ctrl uut (
        .clk       ( clk ),
        .srst      ( srst ),
        .i_hi_req  ( c_req[1] ),
        .i_hi_cmd  ( c_cmd[1] ),
        .o_hi_rdy  ( c_rdy[1] ),
        .o_hi_ack  ( c_ack[1] ),
        .o_hi_resp ( c_resp[1] ),
        .i_lo_req  ( c_req[0] ),
        .i_lo_cmd  ( c_cmd[0] ),
        .o_lo_rdy  ( c_rdy[0] ),
        .o_lo_ack  ( c_ack[0] ),
        .o_lo_resp ( c_resp[0] ),
        .o_p0_req  ( p_req[0] ),
        .o_p0_cmd  ( p_cmd[0] ),
        .i_p0_rdy  ( p_rdy[0] ),
        .i_p0_ack  ( p_ack[0] ),
        .i_p0_resp ( p_resp[0] ),
        .o_p1_req  ( p_req[1] ),
        .o_p1_cmd  ( p_cmd[1] ),
        .i_p1_rdy  ( p_rdy[1] ),
        .i_p1_ack  ( p_ack[1] ),
        .i_p1_resp ( p_resp[1] )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic flag_error(input string what);
        $display("error at %0t: %s", $time, what);
        protocol_cnt++;
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatch, %0d protocol, %0d timeout",
                 mismatch_cnt, protocol_cnt, timeout_cnt);
    endtask

    task automatic end_on_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        timeout_cnt++;
        report_counts();
        $display("Test failed");
        $finish;
    endtask

    function automatic db_pkg::db_req_t make_cmd(input db_pkg::command_t command,
                                                  input logic [`DB_KEY_WID-1:0] key,
                                                  input logic [`DB_VALUE_WID-1:0] value);
        db_pkg::db_req_t cmd;
        cmd.command   = command;
        cmd.key       = key;
        cmd.set_value = value;
        return cmd;
    endfunction

    // GET misses report ERROR while SET and UNSET always report OK
    task automatic table_op(input logic [1:0] bank, input db_pkg::db_req_t cmd,
                            output db_pkg::db_resp_t resp);
        logic [`DB_KEY_WID+1:0] tkey;
        tkey = {bank, cmd.key};
        resp = '0;
        resp.status  = db_pkg::STATUS_OK;
        resp.get_key = cmd.key;
        case (cmd.command)
            db_pkg::COMMAND_GET: begin
                if (tables.exists(tkey)) begin
                    resp.get_valid = 1'b1;
                    resp.get_value = tables[tkey];
                end else begin
                    resp.status = db_pkg::STATUS_ERROR;
                end
            end
            db_pkg::COMMAND_SET: tables[tkey] = cmd.set_value;
            db_pkg::COMMAND_UNSET: tables.delete(tkey);
            default: ;
        endcase
    endtask

    // Hold one controller request until accepted and wait for its ack
    task automatic issue(input int idx, input db_pkg::db_req_t cmd);
        int cnt;
        @(posedge clk);
        #1;
        c_req[idx] = 1'b1;
        c_cmd[idx] = cmd;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                end_on_timeout($sformatf("controller %0d never accepted", idx));
            end
        end while (c_rdy[idx] !== 1'b1);
        @(posedge clk);
        #1;
        c_req[idx] = 1'b0;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                end_on_timeout($sformatf("controller %0d got no ack", idx));
            end
        end while (c_ack[idx] !== 1'b1);
    endtask

    task automatic run_ctrl(input int idx, input int count);
        logic [31:0]     r;
        db_pkg::db_req_t cmd;
        repeat (count) begin
            r = $random(seed);
            repeat (r[1:0]) @(posedge clk);
            cmd.command   = (r[3:2] == 2'd0) ? db_pkg::COMMAND_GET : db_pkg::command_t'(r[3:2]);
            cmd.key       = key_pool[{$random(seed)} % 6];
            cmd.set_value = r[31:16];
            issue(idx, cmd);
        end
    endtask

    // Behavioral table with random rdy and ack delays and an occasional long stall
    task automatic serve_table(input int idx);
        int               cnt;
        int               delay;
        db_pkg::db_req_t  cmd;
        db_pkg::db_resp_t resp;
        forever begin
            cnt = 0;
            do begin
                @(negedge clk);
                cnt++;
                if (cnt > IDLE_LIMIT) begin
                    end_on_timeout($sformatf("table %0d saw no request", idx));
                end
            end while (p_req[idx] !== 1'b1);
            delay = {$random(seed)} % 16;
            delay = (delay == 0) ? STALL_CYCLES : delay % 3;
            repeat (delay + 1) begin
                @(posedge clk);
                #1;
            end
            p_rdy[idx] = 1'b1;
            @(negedge clk);
            if (p_req[idx] !== 1'b1) begin
                flag_error($sformatf("table %0d req dropped before rdy", idx));
            end
            cmd = p_cmd[idx];
            @(posedge clk);
            #1;
            p_rdy[idx] = 1'b0;
            table_op(2'(idx), cmd, resp);
            repeat ({$random(seed)} % 4) begin
                @(posedge clk);
                #1;
            end
            p_ack[idx]  = 1'b1;
            p_resp[idx] = resp;
            @(posedge clk);
            #1;
            p_ack[idx] = 1'b0;
        end
    endtask

    task automatic check_resp(input int idx);
        string name;
        name = (idx == 1) ? "o_hi_resp" : "o_lo_resp";
        check_val({name, ".status"}, 32'(c_resp[idx].status), 32'(exp_resp.status));
        check_val({name, ".get_valid"}, 32'(c_resp[idx].get_valid), 32'(exp_resp.get_valid));
        if (exp_resp.get_valid) begin
            check_val({name, ".get_key"}, 32'(c_resp[idx].get_key), 32'(exp_resp.get_key));
            check_val({name, ".get_value"}, 32'(c_resp[idx].get_value),
                      32'(exp_resp.get_value));
        end
    endtask

    initial begin
        p_rdy     = 2'b00;
        p_ack     = 2'b00;
        p_resp[0] = '0;
        p_resp[1] = '0;
        fork
            serve_table(0);
            serve_table(1);
        join
    end

    // Sampled mid cycle where every signal has settled
    initial begin
        busy     = 1'b0;
        reached  = 1'b0;
        owner    = 0;
        exp_cmd  = '0;
        exp_resp = '0;
        forever begin
            @(negedge clk);
            if (srst) begin
                if (c_ack !== 2'b00 || p_req !== 2'b00) begin
                    flag_error("req or ack output high during reset");
                end
            end else begin
                // Return path first since an accept may follow in the same cycle
                for (int i = 0; i < 2; i++) begin
                    if (c_ack[i] === 1'b1) begin
                        ack_cnt[i]++;
                        ack_time[i] = $time;
                        if (!busy || !reached) begin
                            flag_error($sformatf("ack to controller %0d with nothing in flight",
                                                 i));
                        end else if (owner != i) begin
                            flag_error($sformatf("ack went to controller %0d, not the owner", i));
                        end else begin
                            check_resp(i);
                        end
                        busy = 1'b0;
                    end
                end
                for (int i = 0; i < 2; i++) begin
                    if (c_req[i] === 1'b1 && c_rdy[i] === 1'b1) begin
                        acc_cnt[i]++;
                        if (busy) begin
                            flag_error("controller accepted while a transaction is in flight");
                        end
                        busy    = 1'b1;
                        reached = 1'b0;
                        owner   = i;
                        exp_cmd = c_cmd[i];
                    end
                end
                if (p_req === 2'b11) begin
                    flag_error("both table reqs high");
                end
                for (int i = 0; i < 2; i++) begin
                    if (p_req[i] === 1'b1) begin
                        if (!busy || reached) begin
                            flag_error($sformatf("table %0d req with no controller request", i));
                        end else begin
                            check_val("table index", 32'(i), 32'(exp_cmd.key[`DB_SEL_BIT]));
                            if (p_rdy[i] === 1'b1) begin
                                p_acc_cnt++;
                                check_val("table cmd", 32'(p_cmd[i]), 32'(exp_cmd));
                                reached = 1'b1;
                                table_op(2'd2, exp_cmd, exp_resp);
                            end
                        end
                    end
                end
            end
        end
    end

    initial begin
        srst     = 1'b1;
        c_req    = 2'b00;
        c_cmd[0] = '0;
        c_cmd[1] = '0;
        repeat (16) @(posedge clk);
        #1;
        srst = 1'b0;
        repeat (2) @(posedge clk);

        // Both controllers request together on an idle path
        fork
            issue(1, make_cmd(db_pkg::COMMAND_SET, 8'h05, 16'h1234));
            issue(0, make_cmd(db_pkg::COMMAND_SET, 8'h85, 16'hbeef));
            begin
                @(posedge clk);
                @(negedge clk);
                if (c_rdy !== 2'b10) begin
                    flag_error("hi not granted ahead of lo");
                end
            end
        join
        if (ack_time[1] >= ack_time[0]) begin
            flag_error("lo ack arrived before hi ack");
        end

        // Hits, a miss after UNSET and a key never written
        issue(1, make_cmd(db_pkg::COMMAND_GET, 8'h05, 16'h0));
        issue(0, make_cmd(db_pkg::COMMAND_GET, 8'h85, 16'h0));
        issue(1, make_cmd(db_pkg::COMMAND_UNSET, 8'h05, 16'h0));
        issue(0, make_cmd(db_pkg::COMMAND_GET, 8'h05, 16'h0));
        issue(1, make_cmd(db_pkg::COMMAND_GET, 8'h77, 16'h0));

        fork
            run_ctrl(1, TXN_PER_CTRL);
            run_ctrl(0, TXN_PER_CTRL);
        join
        repeat (4) @(posedge clk);

        check_val("o_hi_ack count", 32'(ack_cnt[1]), 32'(acc_cnt[1]));
        check_val("o_lo_ack count", 32'(ack_cnt[0]), 32'(acc_cnt[0]));
        check_val("table accepts", 32'(p_acc_cnt), 32'(acc_cnt[0] + acc_cnt[1]));

        report_counts();
        if (mismatch_cnt + protocol_cnt + timeout_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : db_ctrl_tb

`default_nettype wire

/* verilog/db_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module db_ctrl (
    input  logic             clk,
    input  logic             srst,

    // High priority controller
    input  logic             i_hi_req,
    input  db_pkg::db_req_t  i_hi_cmd,
    output logic             o_hi_rdy,
    output logic             o_hi_ack,
    output db_pkg::db_resp_t o_hi_resp,

    // Low priority controller
    input  logic             i_lo_req,
    input  db_pkg::db_req_t  i_lo_cmd,
    output logic             o_lo_rdy,
    output logic             o_lo_ack,
    output db_pkg::db_resp_t o_lo_resp,

    // Table peripheral 0
    output logic             o_p0_req,
    output db_pkg::db_req_t  o_p0_cmd,
    input  logic             i_p0_rdy,
    input  logic             i_p0_ack,
    input  db_pkg::db_resp_t i_p0_resp,

    // Table peripheral 1
    output logic             o_p1_req,
    output db_pkg::db_req_t  o_p1_cmd,
    input  logic             i_p1_rdy,
    input  logic             i_p1_ack,
    input  db_pkg::db_resp_t i_p1_resp
);

    // Arbiter to proxy
    logic             arb_req;
    db_pkg::db_req_t  arb_cmd;
    logic             arb_rdy;
    logic             arb_ack;
    db_pkg::db_resp_t arb_resp;

    // Proxy to demux
    logic             prx_req;
    db_pkg::db_req_t  prx_cmd;
    logic             prx_rdy;
    logic             prx_ack;
    db_pkg::db_resp_t prx_resp;

    db_prio_arb u_arb (
        .clk       ( clk ),
        .srst      ( srst ),
        .i_hi_req  ( i_hi_req ),
        .i_hi_cmd  ( i_hi_cmd ),
        .o_hi_rdy  ( o_hi_rdy ),
        .o_hi_ack  ( o_hi_ack ),
        .o_hi_resp ( o_hi_resp ),
        .i_lo_req  ( i_lo_req ),
        .i_lo_cmd  ( i_lo_cmd ),
        .o_lo_rdy  ( o_lo_rdy ),
        .o_lo_ack  ( o_lo_ack ),
        .o_lo_resp ( o_lo_resp ),
        .o_req     ( arb_req ),
        .o_cmd     ( arb_cmd ),
        .i_rdy     ( arb_rdy ),
        .i_ack     ( arb_ack ),
        .i_resp    ( arb_resp )
    );

    db_req_proxy u_proxy (
        .clk    ( clk ),
        .srst   ( srst ),
        .i_req  ( arb_req ),
        .i_cmd  ( arb_cmd ),
        .o_rdy  ( arb_rdy ),
        .o_ack  ( arb_ack ),
        .o_resp ( arb_resp ),
        .o_req  ( prx_req ),
        .o_cmd  ( prx_cmd ),
        .i_rdy  ( prx_rdy ),
        .i_ack  ( prx_ack ),
        .i_resp ( prx_resp )
    );

    db_key_demux u_demux (
        .clk       ( clk ),
        .srst      ( srst ),
        .i_req     ( prx_req ),
        .i_cmd     ( prx_cmd ),
        .o_rdy     ( prx_rdy ),
        .o_ack     ( prx_ack ),
        .o_resp    ( prx_resp ),
        .o_p0_req  ( o_p0_req ),
        .o_p0_cmd  ( o_p0_cmd ),
        .i_p0_rdy  ( i_p0_rdy ),
        .i_p0_ack  ( i_p0_ack ),
        .i_p0_resp ( i_p0_resp ),
        .o_p1_req  ( o_p1_req ),
        .o_p1_cmd  ( o_p1_cmd ),
        .i_p1_rdy  ( i_p1_rdy ),
        .i_p1_ack  ( i_p1_ack ),
        .i_p1_resp ( i_p1_resp )
    );

endmodule : db_ctrl

`default_nettype wire

/* verilog/db_key_demux.sv */
`timescale 1ns/100ps
`default_nettype none

`include "db_defs.svh"

module db_key_demux (
    input  logic             clk,
    input  logic             srst,

    // From the proxy
    input  logic             i_req,
    input  db_pkg::db_req_t  i_cmd,
    output logic             o_rdy,
    output logic             o_ack,
    output db_pkg::db_resp_t o_resp,

    // Table peripheral 0, key select bit low
    output logic             o_p0_req,
    output db_pkg::db_req_t  o_p0_cmd,
    input  logic             i_p0_rdy,
    input  logic             i_p0_ack,
    input  db_pkg::db_resp_t i_p0_resp,

    // Table peripheral 1, key select bit high
    output logic             o_p1_req,
    output db_pkg::db_req_t  o_p1_cmd,
    input  logic             i_p1_rdy,
    input  logic             i_p1_ack,
    input  db_pkg::db_resp_t i_p1_resp
);

    logic             sel;
    logic             sel_ack;
    db_pkg::db_resp_t sel_resp;

    // Key held by the proxy until ack, so the select is stable
    assign sel = i_cmd.key[`DB_SEL_BIT];

    // Only the addressed table sees req
    assign o_p0_req = i_req & ~sel;
    assign o_p1_req = i_req & sel;

    // Command fans out to both tables
    assign o_p0_cmd = i_cmd;
    assign o_p1_cmd = i_cmd;

    // Pick the addressed table's handshake and response
    always_comb begin
        if (sel) begin
            o_rdy    = i_p1_rdy;
            sel_ack  = i_p1_ack;
            sel_resp = i_p1_resp;
        end else begin
            o_rdy    = i_p0_rdy;
            sel_ack  = i_p0_ack;
            sel_resp = i_p0_resp;
        end
    end

    // One cycle on the return path
    always_ff @(posedge clk) begin
        if (srst) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= sel_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_ack) begin
            o_resp <= sel_resp;
        end
    end

endmodule : db_key_demux

`default_nettype wire

/* verilog/db_req_proxy.sv */
`timescale 1ns/100ps
`default_nettype none

module db_req_proxy (
    input  logic             clk,
    input  logic             srst,

    // From the arbiter
    input  logic             i_req,
    input  db_pkg::db_req_t  i_cmd,
    output logic             o_rdy,
    output logic             o_ack,
    output db_pkg::db_resp_t o_resp,

    // Toward the demux
    output logic             o_req,
    output db_pkg::db_req_t  o_cmd,
    input  logic             i_rdy,
    input  logic             i_ack,
    input  db_pkg::db_resp_t i_resp
);

    logic            pending;
    logic            in_progress;
    logic            up_accept;
    logic            down_accept;
    db_pkg::db_req_t ctx_q;

    assign up_accept   = i_req & o_rdy;
    assign down_accept = pending & i_rdy;

    // Request latched, waiting for the downstream rdy
    always_ff @(posedge clk) begin
        if (srst) begin
            pending <= 1'b0;
        end else if (up_accept) begin
            pending <= 1'b1;
        end else if (down_accept) begin
            pending <= 1'b0;
        end
    end

    // Accepted downstream, waiting for ack
    always_ff @(posedge clk) begin
        if (srst) begin
            in_progress <= 1'b0;
        end else if (down_accept) begin
            in_progress <= 1'b1;
        end else if (i_ack) begin
            in_progress <= 1'b0;
        end
    end

    // Context stays put until the next upstream accept
    always_ff @(posedge clk) begin
        if (up_accept) begin
            ctx_q <= i_cmd;
        end
    end

    // Registered rdy breaks the path back to the controllers
    assign o_rdy = ~pending & ~in_progress;
    assign o_req = pending;
    assign o_cmd = ctx_q;

    // Return path passes straight through
    assign o_ack  = i_ack;
    assign o_resp = i_resp;

endmodule : db_req_proxy

`default_nettype wire

/* verilog/db_prio_arb.sv */
`timescale 1ns/100ps
`default_nettype none

module db_prio_arb (
    input  logic             clk,
    input  logic             srst,

    // High priority controller
    input  logic             i_hi_req,
    input  db_pkg::db_req_t  i_hi_cmd,
    output logic             o_hi_rdy,
    output logic             o_hi_ack,
    output db_pkg::db_resp_t o_hi_resp,

    // Low priority controller
    input  logic             i_lo_req,
    input  db_pkg::db_req_t  i_lo_cmd,
    output logic             o_lo_rdy,
    output logic             o_lo_ack,
    output db_pkg::db_resp_t o_lo_resp,

    // Shared downstream channel
    output logic             o_req,
    output db_pkg::db_req_t  o_cmd,
    input  logic             i_rdy,
    input  logic             i_ack,
    input  db_pkg::db_resp_t i_resp
);

    logic accept;
    logic owner_hi;
    logic ack_to_hi;
    logic ack_to_lo;

    // Hi wins whenever it is requesting
    always_comb begin
        o_req = i_hi_req | i_lo_req;
        if (i_hi_req) begin
            o_cmd = i_hi_cmd;
        end else begin
            o_cmd = i_lo_cmd;
        end
    end

    // Lo only sees rdy when hi is quiet
    assign o_hi_rdy = i_rdy & i_hi_req;
    assign o_lo_rdy = i_rdy & ~i_hi_req;

    assign accept = o_req & i_rdy;

    // Owner of the transaction in flight, lo after reset
    always_ff @(posedge clk) begin
        if (srst) begin
            owner_hi <= 1'b0;
        end else if (accept) begin
            owner_hi <= i_hi_req;
        end
    end

    // Steer the returning ack to the owner
    assign ack_to_hi = i_ack & owner_hi;
    assign ack_to_lo = i_ack & ~owner_hi;

    always_ff @(posedge clk) begin
        if (srst) begin
            o_hi_ack <= 1'b0;
            o_lo_ack <= 1'b0;
        end else begin
            o_hi_ack <= ack_to_hi;
            o_lo_ack <= ack_to_lo;
        end
    end

    // Response copies, each one meaningful only with its side's ack
    always_ff @(posedge clk) begin
        if (ack_to_hi) begin
            o_hi_resp <= i_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (ack_to_lo) begin
            o_lo_resp <= i_resp;
        end
    end

endmodule : db_prio_arb

`default_nettype wire

/* verilog/db_pkg.sv */
`default_nettype none

`include "db_defs.svh"

package db_pkg;

    // Table commands
    typedef enum logic [1:0] {
        COMMAND_NOP   = 2'd0,
        COMMAND_GET   = 2'd1,
        COMMAND_SET   = 2'd2,
        COMMAND_UNSET = 2'd3
    } command_t;

    // Response status
    typedef enum logic [1:0] {
        STATUS_OK          = 2'd0,
        STATUS_ERROR       = 2'd1,
        STATUS_TIMEOUT     = 2'd2,
        STATUS_UNSPECIFIED = 2'd3
    } status_t;

    // Controller to peripheral, 26 bits
    typedef struct packed {
        command_t                 command;
        logic [`DB_KEY_WID-1:0]   key;
        logic [`DB_VALUE_WID-1:0] set_value;
    } db_req_t;

    // Peripheral to controller, 27 bits
    typedef struct packed {
        status_t                  status;
        logic                     get_valid;
        logic [`DB_KEY_WID-1:0]   get_key;
        logic [`DB_VALUE_WID-1:0] get_value;
    } db_resp_t;

endpackage : db_pkg

`default_nettype wire

/* verilog/db_defs.svh */
`ifndef DB_DEFS_SVH
`define DB_DEFS_SVH

// Key and value widths of the table interface
`define DB_KEY_WID   8
`define DB_VALUE_WID 16

// Top key bit picks the table peripheral
`define DB_SEL_BIT   (`DB_KEY_WID - 1)

`endif
